// ==== build.f ====
logic/mem_pkg.sv
logic/axi_pkg.sv
logic/access_decode.sv
logic/load_extract.sv
logic/mem_access_fsm.sv
logic/mem_stage.sv
sim/mem_stage_assert.sv
sim/mem_checker.sv
sim/tb_mem_stage.sv

// ==== logic/access_decode.sv ====
module access_decode (
    input  mem_pkg::mem_op_t             op,
    input  logic [mem_pkg::XLEN-1:0]     addr,
    input  logic [mem_pkg::XLEN-1:0]     store_data,
    input  logic                         valid_in,
    input  logic [3:0]                   trap_in,
    output logic                         is_load,
    output logic                         is_store,
    output logic [3:0]                   trap_out,
    output axi_pkg::size_t               size,
    output logic [axi_pkg::STRB_W-1:0]   wstrb,
    output logic [axi_pkg::DATA_W-1:0]   wdata
);

    logic [mem_pkg::OFFSET_W-1:0] offset;
    logic [axi_pkg::STRB_W-1:0]   byte_mask;
    logic                         misaligned;
    mem_pkg::trap_t               misalign_code;

    assign offset = addr[mem_pkg::OFFSET_W-1:0];

    assign is_load = (op >= mem_pkg::LB) && (op <= mem_pkg::LWU);
    assign is_store = (op >= mem_pkg::SB) && (op <= mem_pkg::SD);

    always_comb begin
        size = axi_pkg::SIZE_1;
        byte_mask = 8'h01;
        case (op)
            mem_pkg::LH, mem_pkg::LHU, mem_pkg::SH: begin
                size = axi_pkg::SIZE_2;
                byte_mask = 8'h03;
            end
            mem_pkg::LW, mem_pkg::LWU, mem_pkg::SW: begin
                size = axi_pkg::SIZE_4;
                byte_mask = 8'h0f;
            end
            mem_pkg::LD, mem_pkg::SD: begin
                size = axi_pkg::SIZE_8;
                byte_mask = 8'hff;
            end
            default: begin
                size = axi_pkg::SIZE_1;
                byte_mask = 8'h01;
            end
        endcase
    end

    // Mask bits 7, 3 and 1 give the offset bits that must be zero for this width.
    assign misaligned = (is_load || is_store)
                        && |(offset & {byte_mask[7], byte_mask[3], byte_mask[1]});

    assign misalign_code = is_load ? mem_pkg::LOAD_MISALIGN : mem_pkg::STORE_MISALIGN;

    always_comb begin
        if (valid_in && (trap_in == mem_pkg::TRAP_NOP) && misaligned) begin
            trap_out = misalign_code;
        end else begin
            trap_out = trap_in;
        end
    end

    // Store data goes onto the byte lanes picked by the offset.
    assign wdata = store_data << {offset, 3'b000};
    assign wstrb = (is_store && !misaligned) ? (byte_mask << offset) : '0;

endmodule

// ==== logic/axi_pkg.sv ====
package axi_pkg;

    localparam int ADDR_W = 32;
    localparam int DATA_W = 64;
    localparam int STRB_W = 8;
    localparam int ID_W = 4;
    localparam int LEN_W = 8;

    localparam logic [ID_W-1:0] AXI_ID = 4'd1;

    typedef enum logic [1:0] {OKAY, EXOKAY, SLVERR, DECERR} resp_t;

    typedef enum logic [1:0] {FIXED, INCR, WRAP} burst_t;

    // Bytes per beat.
    typedef enum logic [2:0] {SIZE_1, SIZE_2, SIZE_4, SIZE_8} size_t;

endpackage

// ==== logic/load_extract.sv ====
module load_extract (
    input  mem_pkg::mem_op_t               op,
    input  logic [mem_pkg::OFFSET_W-1:0]   offset,
    input  logic [axi_pkg::DATA_W-1:0]     rdata,
    output logic [mem_pkg::XLEN-1:0]       load_data
);

    logic [axi_pkg::DATA_W-1:0] shifted;

    // Bring the addressed byte down to lane 0.
    assign shifted = rdata >> {offset, 3'b000};

    always_comb begin
        case (op)
            mem_pkg::LB: begin
                load_data = {{56{shifted[7]}}, shifted[7:0]};
            end
            mem_pkg::LH: begin
                load_data = {{48{shifted[15]}}, shifted[15:0]};
            end
            mem_pkg::LW: begin
                load_data = {{32{shifted[31]}}, shifted[31:0]};
            end
            mem_pkg::LD: begin
                load_data = shifted;
            end
            mem_pkg::LBU: begin
                load_data = {56'b0, shifted[7:0]};
            end
            mem_pkg::LHU: begin
                load_data = {48'b0, shifted[15:0]};
            end
            mem_pkg::LWU: begin
                load_data = {32'b0, shifted[31:0]};
            end
            default: begin
                load_data = '0;
            end
        endcase
    end

endmodule

// ==== logic/mem_access_fsm.sv ====
module mem_access_fsm (
    input  logic                         clk,
    input  logic                         rst,
    input  logic                         valid_in,
    input  logic                         conflict,
    input  logic                         wb_ready,
    input  mem_pkg::mem_op_t             op,
    input  logic                         is_load,
    input  logic                         is_store,
    input  logic [3:0]                   trap_out,
    output logic                         valid_out,
    output logic                         ready,
    output logic                         awvalid,
    input  logic                         awready,
    output logic                         wvalid,
    output logic                         wlast,
    input  logic                         wready,
    input  logic                         bvalid,
    input  logic [1:0]                   bresp,
    input  logic [axi_pkg::ID_W-1:0]     bid,
    output logic                         bready,
    output logic                         arvalid,
    input  logic                         arready,
    input  logic                         rvalid,
    input  logic [1:0]                   rresp,
    input  logic [axi_pkg::DATA_W-1:0]   rdata,
    input  logic                         rlast,
    input  logic [axi_pkg::ID_W-1:0]     rid,
    output logic                         rready,
    output logic [axi_pkg::DATA_W-1:0]   rdata_q
);

    typedef enum logic [2:0] {
        IDLE,
        RD_ADDR,
        RD_DATA,
        WR_ADDR,
        WR_DATA,
        WR_RESP,
        FINISH
    } state_t;

    state_t state;
    state_t state_next;
    logic   start_access;
    logic   pass_through;
    logic   read_done;
    logic   write_done;

    assign start_access = valid_in && (trap_out == mem_pkg::TRAP_NOP) && !conflict
                          && (is_load || is_store);

    // A trap goes through even while a conflict is raised.
    assign pass_through = valid_in && ((trap_out != mem_pkg::TRAP_NOP)
                          || (!conflict && (op == mem_pkg::MEM_NOP)));

    // Beats with a foreign ID or an error response are ignored.
    assign read_done = rvalid && (rid == axi_pkg::AXI_ID) && rlast
                       && ((rresp == axi_pkg::OKAY) || (rresp == axi_pkg::EXOKAY));
    assign write_done = bvalid && (bid == axi_pkg::AXI_ID)
                        && ((bresp == axi_pkg::OKAY) || (bresp == axi_pkg::EXOKAY));

    always_comb begin
        state_next = state;
        case (state)
            IDLE: begin
                if (start_access) begin
                    state_next = is_load ? RD_ADDR : WR_ADDR;
                end
            end
            RD_ADDR: if (arready) state_next = RD_DATA;
            RD_DATA: if (read_done) state_next = FINISH;
            WR_ADDR: if (awready) state_next = WR_DATA;
            WR_DATA: if (wready) state_next = WR_RESP;
            WR_RESP: if (write_done) state_next = FINISH;
            FINISH: if (wb_ready) state_next = IDLE;
            default: state_next = IDLE;
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state <= IDLE;
        end else begin
            state <= state_next;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            rdata_q <= '0;
        end else if (state == RD_DATA) begin
            rdata_q <= rdata;
        end
    end

    assign arvalid = (state == RD_ADDR);
    assign rready = (state == RD_DATA);
    assign awvalid = (state == WR_ADDR);
    assign wvalid = (state == WR_DATA);
    assign wlast = (state == WR_DATA);
    assign bready = (state == WR_RESP);

    always_comb begin
        case (state)
            IDLE: begin
                valid_out = pass_through;
                ready = !valid_in || (pass_through && wb_ready);
            end
            FINISH: begin
                valid_out = 1'b1;
                ready = wb_ready;
            end
            default: begin
                valid_out = 1'b0;
                ready = 1'b0;
            end
        endcase
    end

endmodule

// ==== logic/mem_pkg.sv ====
package mem_pkg;

    localparam int XLEN = 64;

    // Byte offset inside one 64-bit word.
    localparam int OFFSET_W = 3;

    typedef enum logic [3:0] {
        MEM_NOP = 4'd0,
        LB      = 4'd1,
        LH      = 4'd2,
        LW      = 4'd3,
        LD      = 4'd4,
        LBU     = 4'd5,
        LHU     = 4'd6,
        LWU     = 4'd7,
        SB      = 4'd8,
        SH      = 4'd9,
        SW      = 4'd10,
        SD      = 4'd11
    } mem_op_t;

    // Codes not listed here are raised upstream and passed along.
    typedef enum logic [3:0] {
        TRAP_NOP       = 4'd0,
        LOAD_MISALIGN  = 4'd4,
        STORE_MISALIGN = 4'd6
    } trap_t;

endpackage

// ==== logic/mem_stage.sv ====
module mem_stage (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          valid_in,
    input  logic [mem_pkg::XLEN-1:0]      addr,
    input  logic [mem_pkg::XLEN-1:0]      store_data,
    input  mem_pkg::mem_op_t              op,
    input  logic [3:0]                    trap_in,
    input  logic                          conflict,
    input  logic                          wb_ready,
    output logic                          valid_out,
    output logic                          ready,
    output logic [mem_pkg::XLEN-1:0]      load_data,
    output logic [3:0]                    trap_out,
    input  logic                          awready,
    output logic                          awvalid,
    output logic [axi_pkg::ADDR_W-1:0]    awaddr,
    output logic [axi_pkg::ID_W-1:0]      awid,
    output logic [axi_pkg::LEN_W-1:0]     awlen,
    output logic [2:0]                    awsize,
    output logic [1:0]                    awburst,
    input  logic                          wready,
    output logic                          wvalid,
    output logic [axi_pkg::DATA_W-1:0]    wdata,
    output logic [axi_pkg::STRB_W-1:0]    wstrb,
    output logic                          wlast,
    output logic                          bready,
    input  logic                          bvalid,
    input  logic [1:0]                    bresp,
    input  logic [axi_pkg::ID_W-1:0]      bid,
    input  logic                          arready,
    output logic                          arvalid,
    output logic [axi_pkg::ADDR_W-1:0]    araddr,
    output logic [axi_pkg::ID_W-1:0]      arid,
    output logic [axi_pkg::LEN_W-1:0]     arlen,
    output logic [2:0]                    arsize,
    output logic [1:0]                    arburst,
    output logic                          rready,
    input  logic                          rvalid,
    input  logic [1:0]                    rresp,
    input  logic [axi_pkg::DATA_W-1:0]    rdata,
    input  logic                          rlast,
    input  logic [axi_pkg::ID_W-1:0]      rid
);

    logic                       is_load;
    logic                       is_store;
    axi_pkg::size_t             size;
    logic [axi_pkg::DATA_W-1:0] rdata_q;

    // Uncached single beats, so the bus sees the byte address as is.
    assign awaddr = addr[axi_pkg::ADDR_W-1:0];
    assign araddr = addr[axi_pkg::ADDR_W-1:0];
    assign awsize = size;
    assign arsize = size;
    assign awid = axi_pkg::AXI_ID;
    assign arid = axi_pkg::AXI_ID;
    assign awlen = '0;
    assign arlen = '0;
    assign awburst = axi_pkg::FIXED;
    assign arburst = axi_pkg::FIXED;

    access_decode u_decode (
        .op         (op),
        .addr       (addr),
        .store_data (store_data),
        .valid_in   (valid_in),
        .trap_in    (trap_in),
        .is_load    (is_load),
        .is_store   (is_store),
        .trap_out   (trap_out),
        .size       (size),
        .wstrb      (wstrb),
        .wdata      (wdata)
    );

    mem_access_fsm u_fsm (
        .clk       (clk),
        .rst       (rst),
        .valid_in  (valid_in),
        .conflict  (conflict),
        .wb_ready  (wb_ready),
        .op        (op),
        .is_load   (is_load),
        .is_store  (is_store),
        .trap_out  (trap_out),
        .valid_out (valid_out),
        .ready     (ready),
        .awvalid   (awvalid),
        .awready   (awready),
        .wvalid    (wvalid),
        .wlast     (wlast),
        .wready    (wready),
        .bvalid    (bvalid),
        .bresp     (bresp),
        .bid       (bid),
        .bready    (bready),
        .arvalid   (arvalid),
        .arready   (arready),
        .rvalid    (rvalid),
        .rresp     (rresp),
        .rdata     (rdata),
        .rlast     (rlast),
        .rid       (rid),
        .rready    (rready),
        .rdata_q   (rdata_q)
    );

    load_extract u_extract (
        .op        (op),
        .offset    (addr[mem_pkg::OFFSET_W-1:0]),
        .rdata     (rdata_q),
        .load_data (load_data)
    );

endmodule

// ==== run.sh ====
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1

verilator --binary --assert --timing -Wno-fatal -f build.f \
    --top-module tb_mem_stage -o tb_mem_stage > build.log 2>&1
if [ $? -ne 0 ]; then
    echo "Build failed, see build.log"
    exit 1
fi

./obj_dir/tb_mem_stage > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "RESULT: FAIL" sim.log; then
    exit 1
fi
exit 0

// ==== sim/mem_checker.sv ====
module mem_checker (
    input logic                   clk,
    input logic                   rst,
    input logic                   valid_in,
    input logic [63:0]            addr,
    input logic [63:0]            store_data,
    input mem_pkg::mem_op_t       op,
    input logic [3:0]             trap_in,
    input logic                   conflict,
    input logic                   wb_ready,
    input logic                   valid_out,
    input logic                   ready,
    input logic [63:0]            load_data,
    input logic [3:0]             trap_out,
    input logic                   awvalid,
    input logic                   awready,
    input logic [31:0]            awaddr,
    input logic [3:0]             awid,
    input logic [7:0]             awlen,
    input logic [2:0]             awsize,
    input logic [1:0]             awburst,
    input logic                   wvalid,
    input logic                   wready,
    input logic [63:0]            wdata,
    input logic [7:0]             wstrb,
    input logic                   bvalid,
    input logic                   bready,
    input logic                   arvalid,
    input logic                   arready,
    input logic [31:0]            araddr,
    input logic [3:0]             arid,
    input logic [7:0]             arlen,
    input logic [2:0]             arsize,
    input logic [1:0]             arburst
);

    logic [63:0] model [0:31];
    int mismatch_count = 0;
    int other_count = 0;
    int retired = 0;
    int n_ar = 0;
    int n_aw = 0;
    int n_w = 0;
    int n_b = 0;

    function automatic int bytes_of(mem_pkg::mem_op_t o);
        case (o)
            mem_pkg::LH, mem_pkg::LHU, mem_pkg::SH: return 2;
            mem_pkg::LW, mem_pkg::LWU, mem_pkg::SW: return 4;
            mem_pkg::LD, mem_pkg::SD: return 8;
            default: return 1;
        endcase
    endfunction

    function automatic logic [2:0] size_code(int n);
        return (n == 8) ? 3'd3 : (n == 4) ? 3'd2 : (n == 2) ? 3'd1 : 3'd0;
    endfunction

    function automatic logic load_op(mem_pkg::mem_op_t o);
        return (o >= mem_pkg::LB) && (o <= mem_pkg::LWU);
    endfunction

    function automatic logic store_op(mem_pkg::mem_op_t o);
        return (o >= mem_pkg::SB) && (o <= mem_pkg::SD);
    endfunction

    function automatic logic [3:0] expect_trap(mem_pkg::mem_op_t o, logic [2:0] off,
                                               logic [3:0] tin);
        if (tin != 4'd0)
            return tin;
        if ((load_op(o) || store_op(o)) && (int'(off) % bytes_of(o) != 0))
            return load_op(o) ? 4'd4 : 4'd6;
        return 4'd0;
    endfunction

    function automatic logic [63:0] expect_load(mem_pkg::mem_op_t o, logic [63:0] word,
                                                logic [2:0] off);
        logic [63:0] v;
        logic [63:0] mask;
        int n;
        n = bytes_of(o);
        mask = (n == 8) ? '1 : ((64'd1 << (8 * n)) - 64'd1);
        v = (word >> (8 * int'(off))) & mask;
        // Signed forms copy the top bit of the field upward.
        if ((o == mem_pkg::LB || o == mem_pkg::LH || o == mem_pkg::LW) && v[8 * n - 1])
            v = v | ~mask;
        return v;
    endfunction

    task automatic report_mismatch(string name, logic [63:0] exp_v, logic [63:0] got_v);
        $display("Mismatch at %0t: %s expected %h got %h", $time, name, exp_v, got_v);
        mismatch_count++;
    endtask

    always @(posedge clk) begin
        logic [2:0] off;
        logic [4:0] idx;
        logic [7:0] exp_strb;
        logic [63:0] exp_wdata;
        logic [3:0] exp_trap;
        logic pass_item;
        int n;
        off = addr[2:0];
        idx = addr[7:3];
        n = bytes_of(op);
        exp_trap = expect_trap(op, off, trap_in);
        pass_item = (exp_trap != 4'd0) || (op == mem_pkg::MEM_NOP && !conflict);
        if (!rst) begin
            // A trapped or empty item is offered downstream in its own cycle.
            if (valid_in && pass_item && (!valid_out || ready != wb_ready)) begin
                $display("Pass-through item not presented in its own cycle at %0t", $time);
                other_count++;
            end
            if (arvalid && arready) begin
                n_ar++;
                if (araddr != addr[31:0])
                    report_mismatch("araddr", 64'(addr[31:0]), 64'(araddr));
                if (arsize != size_code(n))
                    report_mismatch("arsize", 64'(size_code(n)), 64'(arsize));
                if (arid != axi_pkg::AXI_ID)
                    report_mismatch("arid", 64'(axi_pkg::AXI_ID), 64'(arid));
                if (arlen != 8'd0)
                    report_mismatch("arlen", 64'd0, 64'(arlen));
                if (arburst != 2'd0)
                    report_mismatch("arburst", 64'd0, 64'(arburst));
            end
            if (awvalid && awready) begin
                n_aw++;
                if (awaddr != addr[31:0])
                    report_mismatch("awaddr", 64'(addr[31:0]), 64'(awaddr));
                if (awsize != size_code(n))
                    report_mismatch("awsize", 64'(size_code(n)), 64'(awsize));
                if (awid != axi_pkg::AXI_ID)
                    report_mismatch("awid", 64'(axi_pkg::AXI_ID), 64'(awid));
                if (awlen != 8'd0)
                    report_mismatch("awlen", 64'd0, 64'(awlen));
                if (awburst != 2'd0)
                    report_mismatch("awburst", 64'd0, 64'(awburst));
            end
            if (wvalid && wready) begin
                n_w++;
                exp_strb = 8'((9'd1 << n) - 9'd1) << off;
                exp_wdata = store_data << (8 * int'(off));
                if (wstrb != exp_strb)
                    report_mismatch("wstrb", 64'(exp_strb), 64'(wstrb));
                if (wdata != exp_wdata)
                    report_mismatch("wdata", exp_wdata, wdata);
                for (int b = 0; b < 8; b++) begin
                    if (exp_strb[b])
                        model[idx][8 * b +: 8] = exp_wdata[8 * b +: 8];
                end
            end
            if (bvalid && bready)
                n_b++;
            if (valid_out && ready) begin
                retired++;
                if (!valid_in) begin
                    $display("Item retired at %0t with no valid input", $time);
                    other_count++;
                end
                if (trap_out != exp_trap)
                    report_mismatch("trap_out", 64'(exp_trap), 64'(trap_out));
                if (exp_trap == 4'd0 && load_op(op)
                        && load_data != expect_load(op, model[idx], off))
                    report_mismatch("load_data", expect_load(op, model[idx], off), load_data);
                if (!load_op(op) && load_data != 64'd0)
                    report_mismatch("load_data", 64'd0, load_data);
                if (exp_trap == 4'd0 && load_op(op)) begin
                    if (n_ar != 1 || n_aw != 0 || n_w != 0) begin
                        $display("Wrong bus traffic for load at %0t", $time);
                        other_count++;
                    end
                end else if (exp_trap == 4'd0 && store_op(op)) begin
                    if (n_ar != 0 || n_aw != 1 || n_w != 1 || n_b != 1) begin
                        $display("Wrong bus traffic for store at %0t", $time);
                        other_count++;
                    end
                end else if (n_ar + n_aw + n_w + n_b != 0) begin
                    $display("Bus activity for a trapped or empty item at %0t", $time);
                    other_count++;
                end
                n_ar = 0;
                n_aw = 0;
                n_w = 0;
                n_b = 0;
            end
        end
    end

endmodule

// ==== sim/mem_stage_assert.sv ====
module mem_stage_assert (
    input logic        clk,
    input logic        rst,
    input logic        arvalid,
    input logic        arready,
    input logic [31:0] araddr,
    input logic        awvalid,
    input logic        awready,
    input logic [31:0] awaddr,
    input logic        wvalid,
    input logic        wready,
    input logic        wlast,
    input logic [63:0] wdata,
    input logic        rready,
    input logic        bready
);

    // A channel holds valid and payload until its transfer.
    ar_hold: assert property (@(posedge clk) disable iff (rst)
        arvalid && !arready |=> arvalid && $stable(araddr))
        else $error("arvalid or araddr changed before arready");
    aw_hold: assert property (@(posedge clk) disable iff (rst)
        awvalid && !awready |=> awvalid && $stable(awaddr))
        else $error("awvalid or awaddr changed before awready");
    w_hold: assert property (@(posedge clk) disable iff (rst)
        wvalid && !wready |=> wvalid && $stable(wdata))
        else $error("wvalid or wdata changed before wready");

    one_addr: assert property (@(posedge clk) disable iff (rst) !(arvalid && awvalid))
        else $error("arvalid and awvalid high together");

    // Single beat, so every data beat is the last.
    w_last: assert property (@(posedge clk) disable iff (rst) wvalid |-> wlast)
        else $error("wvalid without wlast");

    idle_in_reset: assert property (@(posedge clk)
        rst |-> !(awvalid || wvalid || bready || arvalid || rready))
        else $error("AXI valid or ready high during reset");

endmodule

bind mem_stage mem_stage_assert u_assert (.*);

// ==== sim/tb_mem_stage.sv ====
module tb_mem_stage;

    logic clk = 1'b0;
    logic rst = 1'b1;
    logic valid_in = 1'b0;
    logic [63:0] addr = '0;
    logic [63:0] store_data = '0;
    mem_pkg::mem_op_t op = mem_pkg::MEM_NOP;
    logic [3:0] trap_in = '0;
    logic conflict = 1'b0;
    logic wb_ready = 1'b0;
    logic valid_out;
    logic ready;
    logic [63:0] load_data;
    logic [3:0] trap_out;
    logic awready = 1'b0;
    logic awvalid;
    logic [31:0] awaddr;
    logic [3:0] awid;
    logic [7:0] awlen;
    logic [2:0] awsize;
    logic [1:0] awburst;
    logic wready = 1'b0;
    logic wvalid;
    logic [63:0] wdata;
    logic [7:0] wstrb;
    logic wlast;
    logic bready;
    logic bvalid = 1'b0;
    logic [1:0] bresp = axi_pkg::OKAY;
    logic [3:0] bid = axi_pkg::AXI_ID;
    logic arready = 1'b0;
    logic arvalid;
    logic [31:0] araddr;
    logic [3:0] arid;
    logic [7:0] arlen;
    logic [2:0] arsize;
    logic [1:0] arburst;
    logic rready;
    logic rvalid = 1'b0;
    logic [1:0] rresp = axi_pkg::OKAY;
    logic [63:0] rdata = '0;
    logic rlast = 1'b1;
    logic [3:0] rid = axi_pkg::AXI_ID;

    logic [63:0] slave_mem [0:31];
    logic [4:0] rd_idx = '0;
    logic [4:0] wr_idx = '0;
    logic rd_pend = 1'b0;
    logic b_pend = 1'b0;
    int ar_delay = 0;
    int r_delay = 0;
    int aw_delay = 0;
    int w_delay = 0;
    int b_delay = 0;
    int issued = 0;
    int tb_errors = 0;

    mem_stage dut (.*);

    mem_checker chk (.*);

    initial begin
        forever #5 clk = ~clk;
    end

    function automatic logic [63:0] fill_word(int i);
        return {32'(i) * 32'h9e37_79b9 + 32'h0123_4567, 32'(i) ^ 32'hc3a5_5a3c};
    endfunction

    function automatic int access_bytes(mem_pkg::mem_op_t o);
        case (o)
            mem_pkg::LH, mem_pkg::LHU, mem_pkg::SH: return 2;
            mem_pkg::LW, mem_pkg::LWU, mem_pkg::SW: return 4;
            mem_pkg::LD, mem_pkg::SD: return 8;
            default: return 1;
        endcase
    endfunction

    function automatic logic [63:0] merge_bytes(logic [63:0] old, logic [63:0] data,
                                                logic [7:0] strb);
        logic [63:0] r;
        r = old;
        for (int b = 0; b < 8; b++) begin
            if (strb[b])
                r[8 * b +: 8] = data[8 * b +: 8];
        end
        return r;
    endfunction

    always @(posedge clk) begin
        wb_ready <= ($urandom_range(0, 3) != 0);
    end

    // Slave memory, each handshake delayed 0 to 3 cycles.
    always @(posedge clk or posedge rst) begin
        if (rst) begin
            arready <= 1'b0;
            rvalid <= 1'b0;
            awready <= 1'b0;
            wready <= 1'b0;
            bvalid <= 1'b0;
            rd_pend <= 1'b0;
            b_pend <= 1'b0;
        end else begin
            if (arvalid && arready) begin
                arready <= 1'b0;
                rd_idx <= araddr[7:3];
                rd_pend <= 1'b1;
                r_delay <= $urandom_range(0, 3);
                ar_delay <= $urandom_range(0, 3);
            end else if (arvalid) begin
                if (ar_delay == 0) arready <= 1'b1;
                else ar_delay <= ar_delay - 1;
            end
            if (rvalid && rready) begin
                rvalid <= 1'b0;
            end else if (rd_pend && !rvalid) begin
                if (r_delay == 0) begin
                    rvalid <= 1'b1;
                    rdata <= slave_mem[rd_idx];
                    rd_pend <= 1'b0;
                end else begin
                    r_delay <= r_delay - 1;
                end
            end
            if (awvalid && awready) begin
                awready <= 1'b0;
                wr_idx <= awaddr[7:3];
                aw_delay <= $urandom_range(0, 3);
            end else if (awvalid) begin
                if (aw_delay == 0) awready <= 1'b1;
                else aw_delay <= aw_delay - 1;
            end
            if (wvalid && wready) begin
                wready <= 1'b0;
                slave_mem[wr_idx] <= merge_bytes(slave_mem[wr_idx], wdata, wstrb);
                b_pend <= 1'b1;
                b_delay <= $urandom_range(0, 3);
                w_delay <= $urandom_range(0, 3);
            end else if (wvalid) begin
                if (w_delay == 0) wready <= 1'b1;
                else w_delay <= w_delay - 1;
            end
            if (bvalid && bready) begin
                bvalid <= 1'b0;
            end else if (b_pend && !bvalid) begin
                if (b_delay == 0) begin
                    bvalid <= 1'b1;
                    b_pend <= 1'b0;
                end else begin
                    b_delay <= b_delay - 1;
                end
            end
        end
    end

    initial begin
        int wait_cycles;
        int n;
        logic accepted;
        logic [4:0] idx;
        logic [2:0] off;
        mem_pkg::mem_op_t o;
        void'($urandom(35345));
        for (int i = 0; i < 32; i++) begin
            slave_mem[i] = fill_word(i);
            chk.model[i] = fill_word(i);
        end
        repeat (5) @(posedge clk);
        rst <= 1'b0;
        for (int k = 0; k < 400; k++) begin
            if ($urandom_range(0, 3) == 0) begin
                valid_in <= 1'b0;
                conflict <= 1'b0;
                @(posedge clk);
            end
            o = mem_pkg::mem_op_t'($urandom_range(0, 11));
            n = access_bytes(o);
            idx = 5'($urandom_range(0, 31));
            off = 3'($urandom_range(0, 7));
            // Most accesses are naturally aligned.
            if ($urandom_range(0, 3) != 0)
                off = off & ~3'(n - 1);
            valid_in <= 1'b1;
            op <= o;
            addr <= 64'h1000 + {56'b0, idx, off};
            store_data <= {$urandom, $urandom};
            trap_in <= ($urandom_range(0, 9) == 0) ? 4'($urandom_range(1, 15)) : 4'd0;
            conflict <= ($urandom_range(0, 3) == 0);
            accepted = 1'b0;
            wait_cycles = 0;
            while (!accepted) begin
                @(posedge clk);
                if (ready) begin
                    accepted = 1'b1;
                end else begin
                    conflict <= ($urandom_range(0, 3) == 0);
                    wait_cycles++;
                    if (wait_cycles > 300) begin
                        $display("Timeout waiting for the stage to accept item %0d", k);
                        $display("RESULT: FAIL");
                        $finish;
                    end
                end
            end
            issued++;
        end
        valid_in <= 1'b0;
        conflict <= 1'b0;
        @(posedge clk);
        if (chk.retired != issued) begin
            $display("Issued %0d items but %0d retired", issued, chk.retired);
            tb_errors++;
        end
        $display("Errors: %0d mismatches, %0d other failures",
                 chk.mismatch_count, chk.other_count + tb_errors);
        if (chk.mismatch_count + chk.other_count + tb_errors == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule
